/* verilog/sram_switch_pkg.sv */
package sram_switch_pkg;

    localparam int num_banks    = 32;
    localparam int bank_words   = 1024;
    localparam int max_len      = 511;
    localparam int num_ports    = 16;
    localparam int search_limit = 64;

    localparam int bank_w  = 5;
    localparam int space_w = 11;    // holds bank_words itself
    localparam int len_w   = 9;
    localparam int dest_w  = 4;
    localparam int count_w = 11;    // a bank can hold up to 1024 one-word packets
    localparam int thr_w   = 5;
    localparam int tick_w  = 7;     // counts up to search_limit

    localparam int thr_max_static   = 1;
    localparam int thr_max_semi     = 17;
    localparam int thr_max_dynamic  = 32;
    localparam int set_size_static  = 2;
    localparam int set_size_semi    = 18;
    localparam int set_size_dynamic = 32;
    localparam int shared_base      = 16;   // first bank of the shared half

    typedef enum logic [1:0] {
        mode_static       = 2'd0,
        mode_semi_dynamic = 2'd1,
        mode_dynamic      = 2'd2
    } match_mode_e;

    typedef enum logic {
        op_write   = 1'b0,
        op_release = 1'b1
    } cmd_op_e;

    typedef struct packed {
        logic [dest_w-1:0] dest;
        logic [len_w-1:0]  length;
        logic [4:0]        spare;
    } cmd_write_t;

    typedef struct packed {
        logic [bank_w-1:0] bank;
        logic [dest_w-1:0] dest;
        logic [len_w-1:0]  length;
    } cmd_release_t;

    typedef union packed {
        cmd_write_t   wr;
        cmd_release_t rel;
    } cmd_body_u;

    typedef struct packed {
        cmd_op_e   op;
        cmd_body_u body;
    } cmd_t;

    typedef struct packed {
        logic              ok;
        logic [bank_w-1:0] bank;
    } grant_t;

    typedef struct packed {
        logic              valid;
        logic              rel;     // set for a release, clear for a reserve
        logic [bank_w-1:0] bank;
        logic [dest_w-1:0] dest;
        logic [len_w-1:0]  length;
    } space_req_t;

endpackage

/* verilog/sram_space_tracker.sv */
module sram_space_tracker
    import sram_switch_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  space_req_t                        space_req,
    input  logic [bank_w-1:0]                 probe_sram,
    input  logic [dest_w-1:0]                 probe_dest,
    output logic [num_banks-1:0][space_w-1:0] free_space,
    output logic [len_w-1:0]                  probe_amount
);

    logic [count_w-1:0] pkt_count [num_banks][num_ports];
    logic [count_w-1:0] probe_count;
    logic [count_w-1:0] cur_count;
    logic [space_w-1:0] cur_space;

    assign cur_space = free_space[space_req.bank];
    assign cur_count = pkt_count[space_req.bank][space_req.dest];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < num_banks; b++) begin
                free_space[b] <= space_w'(bank_words);
                for (int d = 0; d < num_ports; d++) begin
                    pkt_count[b][d] <= '0;
                end
            end
        end else if (space_req.valid) begin
            if (space_req.rel) begin
                free_space[space_req.bank] <= cur_space + space_w'(space_req.length);
                pkt_count[space_req.bank][space_req.dest] <= cur_count - count_w'(1);
            end else begin
                free_space[space_req.bank] <= cur_space - space_w'(space_req.length);
                pkt_count[space_req.bank][space_req.dest] <= cur_count + count_w'(1);
            end
        end
    end

    // the matcher compares against a 9 bit amount, larger counts saturate
    assign probe_count = pkt_count[probe_sram][probe_dest];

    always_comb begin
        if (probe_count > count_w'(max_len))
            probe_amount = len_w'(max_len);
        else
            probe_amount = probe_count[len_w-1:0];
    end

    a_reserve_fits : assert property (@(posedge clk) disable iff (!rst_n)
        space_req.valid && !space_req.rel |-> cur_space >= space_w'(space_req.length))
        else $error("reserve of %0d words exceeds free space of bank %0d",
                    space_req.length, space_req.bank);

    a_release_bound : assert property (@(posedge clk) disable iff (!rst_n)
        space_req.valid && space_req.rel
            |-> (int'(cur_space) + int'(space_req.length)) <= bank_words)
        else $error("release pushes bank %0d beyond its capacity", space_req.bank);

endmodule

/* verilog/port_sram_matcher.sv */
module port_sram_matcher
    import sram_switch_pkg::*;
#(
    parameter int unsigned PORT_IDX = 0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  match_mode_e                       match_mode,
    input  logic [thr_w-1:0]                  threshold,
    input  logic                              match_enable,
    input  logic [dest_w-1:0]                 new_dest_port,
    input  logic [len_w-1:0]                  new_length,
    input  logic [num_banks-1:0][space_w-1:0] free_space,
    input  logic [num_banks-1:0]              occupied,
    input  logic [len_w-1:0]                  probe_amount,
    output logic [bank_w-1:0]                 probe_sram,
    output logic                              match_end,
    output logic                              match_ok,
    output logic [bank_w-1:0]                 matched_sram
);

    typedef enum logic [1:0] {
        st_idle,
        st_search,
        st_done
    } state_e;

    state_e             state;
    logic [dest_w-1:0]  own_pair;
    logic [bank_w-1:0]  seq_idx;
    logic [bank_w-1:0]  seq_last;
    logic [tick_w-1:0]  tick;
    logic [tick_w-1:0]  thr_max;
    logic [tick_w-1:0]  thr_eff;
    logic               found;
    logic [bank_w-1:0]  best_sram;
    logic [len_w-1:0]   best_amount;
    logic [dest_w-1:0]  last_dest;
    logic               last_valid;
    logic               fast_hit;
    logic               cand_ok;
    logic               cand_better;
    logic               next_found;
    logic [bank_w-1:0]  next_best;
    logic               thr_met;
    logic               give_up;

    function automatic logic in_bank_set(match_mode_e mode, logic [bank_w-1:0] bank,
                                         logic [dest_w-1:0] pair);
        case (mode)
            mode_static:       return bank[bank_w-1:1] == pair;
            mode_semi_dynamic: return bank[bank_w-1] || (bank[bank_w-1:1] == pair);
            default:           return 1'b1;
        endcase
    endfunction

    assign own_pair = dest_w'(PORT_IDX);   // the port owns banks 2p and 2p+1

    // seq_idx walks the mode's bank set, probe_sram is its bank number
    always_comb begin
        case (match_mode)
            mode_static: begin
                probe_sram = {own_pair, seq_idx[0]};
                seq_last   = bank_w'(set_size_static - 1);
                thr_max    = tick_w'(thr_max_static);
            end
            mode_semi_dynamic: begin
                if (seq_idx < bank_w'(2))
                    probe_sram = {own_pair, seq_idx[0]};
                else
                    probe_sram = seq_idx + bank_w'(shared_base - 2);
                seq_last = bank_w'(set_size_semi - 1);
                thr_max  = tick_w'(thr_max_semi);
            end
            default: begin
                probe_sram = {own_pair, 1'b0} + seq_idx;  // wraps around all banks
                seq_last   = bank_w'(set_size_dynamic - 1);
                thr_max    = tick_w'(thr_max_dynamic);
            end
        endcase
    end

    assign thr_eff = (tick_w'(threshold) > thr_max) ? thr_max : tick_w'(threshold);

    assign fast_hit = last_valid && (new_dest_port == last_dest)
                      && (free_space[matched_sram] >= space_w'(new_length))
                      && !occupied[matched_sram]
                      && in_bank_set(match_mode, matched_sram, own_pair);

    assign cand_ok     = (free_space[probe_sram] >= space_w'(new_length)) && !occupied[probe_sram];
    assign cand_better = cand_ok && (!found || (probe_amount > best_amount));
    assign next_found  = found || cand_ok;
    assign next_best   = cand_better ? probe_sram : best_sram;
    assign thr_met     = (tick + tick_w'(1)) >= thr_eff;   // counts the probe of this cycle
    assign give_up     = (tick + tick_w'(1)) >= tick_w'(search_limit);

    assign match_end = (state == st_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            seq_idx    <= '0;
            match_ok   <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    seq_idx <= '0;
                    tick    <= '0;
                    found   <= 1'b0;
                    if (match_enable) begin
                        if (fast_hit) begin
                            match_ok <= 1'b1;  // reuse the remembered bank
                            state    <= st_done;
                        end else begin
                            state <= st_search;
                        end
                    end
                end
                st_search: begin
                    seq_idx <= (seq_idx == seq_last) ? '0 : seq_idx + bank_w'(1);
                    tick    <= tick + tick_w'(1);
                    found   <= next_found;
                    if (cand_better) begin
                        best_sram   <= probe_sram;
                        best_amount <= probe_amount;
                    end
                    if (thr_met && next_found) begin
                        matched_sram <= next_best;
                        match_ok     <= 1'b1;
                        last_dest    <= new_dest_port;
                        last_valid   <= 1'b1;
                        state        <= st_done;
                    end else if (give_up) begin
                        match_ok   <= 1'b0;   // nothing fits, the write is dropped
                        last_valid <= 1'b0;
                        state      <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_enable_idle : assert property (@(posedge clk) disable iff (!rst_n)
        match_enable |-> state == st_idle)
        else $error("match_enable while a search is still running");

    a_bank_in_set : assert property (@(posedge clk) disable iff (!rst_n)
        match_end && match_ok |-> in_bank_set(match_mode, matched_sram, own_pair))
        else $error("matched bank %0d outside the mode's bank set", matched_sram);

endmodule

/* verilog/port_cmd_ctrl.sv */
module port_cmd_ctrl
    import sram_switch_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_req,
    input  cmd_t              cmd,
    input  logic              match_end,
    input  logic              match_ok,
    input  logic [bank_w-1:0] matched_sram,
    output logic              cmd_ack,
    output grant_t            grant,
    output logic              match_enable,
    output logic [dest_w-1:0] new_dest_port,
    output logic [len_w-1:0]  new_length,
    output space_req_t        space_req
);

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_match,
        st_rel,
        st_ack
    } state_e;

    state_e            state;
    cmd_t              cmd_q;
    logic              is_write;
    logic [bank_w-1:0] dec_bank;

    assign is_write = (cmd_q.op == op_write);

    // the same word carries dest and length at different offsets per op
    always_comb begin
        if (is_write) begin
            new_dest_port = cmd_q.body.wr.dest;
            new_length    = cmd_q.body.wr.length;
            dec_bank      = matched_sram;
        end else begin
            new_dest_port = cmd_q.body.rel.dest;
            new_length    = cmd_q.body.rel.length;
            dec_bank      = cmd_q.body.rel.bank;
        end
    end

    assign match_enable = (state == st_decode) && is_write;
    assign cmd_ack      = (state == st_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= st_idle;
            space_req.valid <= 1'b0;
        end else begin
            space_req.valid <= 1'b0;   // single cycle update pulse
            case (state)
                st_idle: begin
                    if (cmd_req) begin
                        cmd_q <= cmd;
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    if (is_write) begin
                        state <= st_match;
                    end else begin
                        space_req <= '{valid: 1'b1, rel: 1'b1, bank: dec_bank,
                                       dest: new_dest_port, length: new_length};
                        state     <= st_rel;
                    end
                end
                st_match: begin
                    if (match_end) begin
                        grant.ok   <= match_ok;
                        grant.bank <= matched_sram;
                        if (match_ok) begin
                            space_req <= '{valid: 1'b1, rel: 1'b0, bank: dec_bank,
                                           dest: new_dest_port, length: new_length};
                        end
                        state <= st_ack;  // reserve lands with the first ack cycle
                    end
                end
                st_rel: begin
                    state <= st_ack;
                end
                default: begin
                    if (!cmd_req)
                        state <= st_idle;
                end
            endcase
        end
    end

    a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack raised while cmd_req is low");

endmodule

/* verilog/sram_switch.sv */
module sram_switch
    import sram_switch_pkg::*;
#(
    parameter int unsigned PORT_IDX = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_req,
    input  cmd_t                 cmd,
    input  match_mode_e          match_mode,
    input  logic [thr_w-1:0]     threshold,
    input  logic [num_banks-1:0] occupied,
    output logic                 cmd_ack,
    output grant_t               grant
);

    logic                              match_enable;
    logic [dest_w-1:0]                 new_dest_port;
    logic [len_w-1:0]                  new_length;
    logic                              match_end;
    logic                              match_ok;
    logic [bank_w-1:0]                 matched_sram;
    logic [bank_w-1:0]                 probe_sram;
    logic [len_w-1:0]                  probe_amount;
    logic [num_banks-1:0][space_w-1:0] free_space;
    space_req_t                        space_req;

    port_cmd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .match_end     (match_end),
        .match_ok      (match_ok),
        .matched_sram  (matched_sram),
        .cmd_ack       (cmd_ack),
        .grant         (grant),
        .match_enable  (match_enable),
        .new_dest_port (new_dest_port),
        .new_length    (new_length),
        .space_req     (space_req)
    );

    port_sram_matcher #(
        .PORT_IDX (PORT_IDX)
    ) u_matcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .match_mode    (match_mode),
        .threshold     (threshold),
        .match_enable  (match_enable),
        .new_dest_port (new_dest_port),
        .new_length    (new_length),
        .free_space    (free_space),
        .occupied      (occupied),
        .probe_amount  (probe_amount),
        .probe_sram    (probe_sram),
        .match_end     (match_end),
        .match_ok      (match_ok),
        .matched_sram  (matched_sram)
    );

    sram_space_tracker u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .space_req    (space_req),
        .probe_sram   (probe_sram),
        .probe_dest   (new_dest_port),   // amounts are looked up for the pending write
        .free_space   (free_space),
        .probe_amount (probe_amount)
    );

endmodule

/* verif/sram_switch_checks.sv */
module sram_switch_checks
    import sram_switch_pkg::*;
#(
    parameter int unsigned PORT_IDX = 0
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              cmd_req,
    input logic                              cmd_ack,
    input cmd_t                              cmd,
    input grant_t                            grant,
    input match_mode_e                       match_mode,
    input logic [num_banks-1:0]              occupied,
    input logic [num_banks-1:0][space_w-1:0] model_free
);
    timeunit 1ns;
    timeprecision 100ps;

    int                err_count = 0;
    int                err_at_start = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    logic              ack_q;
    logic              new_write;
    logic              fit_exists;
    logic              fast_expected;
    logic              last_valid;
    logic [bank_w-1:0] last_bank;
    logic [dest_w-1:0] last_dest;
    logic [len_w-1:0]  wr_len;

    // static owns banks 2p and 2p+1, semi-dynamic adds the upper half, dynamic takes all
    function automatic logic bank_allowed(match_mode_e mode, logic [bank_w-1:0] bank);
        if (mode == mode_dynamic)
            return 1'b1;
        if ((int'(bank) >> 1) == int'(PORT_IDX))
            return 1'b1;
        return (mode == mode_semi_dynamic) && (int'(bank) >= 16);
    endfunction

    assign wr_len    = cmd.body.wr.length;
    assign new_write = cmd_ack && !ack_q && (cmd.op == op_write);

    always_comb begin
        fit_exists = 1'b0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_allowed(match_mode, bank_w'(b)) && !occupied[b]
                && model_free[b] >= space_w'(wr_len))
                fit_exists = 1'b1;
        end
    end

    assign fast_expected = last_valid && (cmd.body.wr.dest == last_dest)
                           && !occupied[last_bank] && bank_allowed(match_mode, last_bank)
                           && model_free[last_bank] >= space_w'(wr_len);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            ack_q <= cmd_ack;
            if (new_write) begin
                last_valid <= grant.ok;  // a drop forgets the remembered bank
                last_bank  <= grant.bank;
                last_dest  <= cmd.body.wr.dest;
            end
        end
    end

    a_ack_rise : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            err_count++;
            $display("cmd_ack rose at %0t while cmd_req was low", $time);
        end

    a_ack_fall : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cmd_ack) |-> !$past(cmd_req))
        else begin
            err_count++;
            $display("cmd_ack fell at %0t before cmd_req was dropped", $time);
        end

    a_grant_stable : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && $past(cmd_ack) |-> $stable(grant))
        else begin
            err_count++;
            $display("grant changed at %0t while cmd_ack was high", $time);
        end

    a_grant_ok : assert property (@(posedge clk) disable iff (!rst_n)
        new_write |-> grant.ok == fit_exists)
        else begin
            err_count++;
            $display("error at %0t: grant.ok expected %0b got %0b",
                     $time, $sampled(fit_exists), $sampled(grant.ok));
        end

    a_grant_legal : assert property (@(posedge clk) disable iff (!rst_n)
        new_write && grant.ok |-> bank_allowed(match_mode, grant.bank)
            && !occupied[grant.bank] && model_free[grant.bank] >= space_w'(wr_len))
        else begin
            err_count++;
            $display("granted bank %0d at %0t is outside the set, occupied or too small",
                     $sampled(grant.bank), $time);
        end

    a_fast_path : assert property (@(posedge clk) disable iff (!rst_n)
        new_write && fast_expected |-> grant.bank == last_bank)
        else begin
            err_count++;
            $display("error at %0t: grant.bank expected %0d got %0d",
                     $time, $sampled(last_bank), $sampled(grant.bank));
        end

    task automatic close_test(input string name);
        tests_run++;
        if (err_count == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err_at_start);
        end
        err_at_start = err_count;
    endtask

endmodule

/* verif/sram_switch_tb.sv */
module sram_switch_tb
    import sram_switch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned port_idx = 5;
    localparam int wait_limit = 200;  // above the longest search plus the handshake

    typedef struct packed {
        logic [bank_w-1:0] bank;
        logic [dest_w-1:0] dest;
        logic [len_w-1:0]  length;
    } held_pkt_t;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic                              cmd_req;
    cmd_t                              cmd;
    match_mode_e                       match_mode;
    logic [thr_w-1:0]                  threshold;
    logic [num_banks-1:0]              occupied;
    logic                              cmd_ack;
    grant_t                            grant;
    logic [num_banks-1:0][space_w-1:0] model_free;
    held_pkt_t                         held[$];

    always #20 clk = ~clk;

    sram_switch #(
        .PORT_IDX (port_idx)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .match_mode (match_mode),
        .threshold  (threshold),
        .occupied   (occupied),
        .cmd_ack    (cmd_ack),
        .grant      (grant)
    );

    sram_switch_checks #(
        .PORT_IDX (port_idx)
    ) u_checks (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .cmd        (cmd),
        .grant      (grant),
        .match_mode (match_mode),
        .occupied   (occupied),
        .model_free (model_free)
    );

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (cmd_ack !== level && cycles < wait_limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (cmd_ack !== level)
            stop_on_timeout(what);
    endtask

    // full four-phase exchange, req is held one more edge after ack is seen
    task automatic send_cmd(input cmd_t c, output grant_t g);
        cmd     = c;
        cmd_req = 1'b1;
        wait_ack(1'b1, "cmd_ack never rose");
        g = grant;
        @(posedge clk);
        #2;
        cmd_req = 1'b0;
        wait_ack(1'b0, "cmd_ack never fell");
    endtask

    task automatic do_write(input logic [dest_w-1:0] dest, input logic [len_w-1:0] length);
        cmd_t   c;
        grant_t g;
        c                = '0;
        c.op             = op_write;
        c.body.wr.dest   = dest;
        c.body.wr.length = length;
        send_cmd(c, g);
        if (g.ok) begin
            model_free[g.bank] = model_free[g.bank] - space_w'(length);
            held.push_back('{bank: g.bank, dest: dest, length: length});
        end
    endtask

    task automatic do_release(input held_pkt_t p);
        cmd_t   c;
        grant_t g;
        c                 = '0;
        c.op              = op_release;
        c.body.rel.bank   = p.bank;
        c.body.rel.dest   = p.dest;
        c.body.rel.length = p.length;
        send_cmd(c, g);
        model_free[p.bank] = model_free[p.bank] + space_w'(p.length);
    endtask

    task automatic release_all();
        held_pkt_t p;
        while (held.size() > 0) begin
            p = held.pop_front();
            do_release(p);
        end
    endtask

    task automatic random_writes(input int count, input logic random_occ);
        for (int i = 0; i < count; i++) begin
            threshold = thr_w'($urandom % 32);
            occupied  = random_occ ? $urandom : '0;
            do_write(dest_w'($urandom % num_ports), len_w'(1 + $urandom % max_len));
        end
        occupied = '0;
    endtask

    initial begin
        void'($urandom(89));
        rst_n      = 1'b0;
        cmd_req    = 1'b0;
        cmd        = '0;
        match_mode = mode_static;
        threshold  = '0;
        occupied   = '0;
        for (int b = 0; b < num_banks; b++)
            model_free[b] = space_w'(bank_words);
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        random_writes(4, 1'b0);
        release_all();
        u_checks.close_test("handshake");

        threshold = thr_w'(1);
        occupied[2*port_idx] = 1'b1;       // first packet lands in the odd bank
        do_write(dest_w'(7), len_w'(20));
        occupied = '0;
        do_write(dest_w'(7), len_w'(20));  // a new search would stop at the even bank
        release_all();
        u_checks.close_test("fast_path");

        occupied = '0;
        occupied[2*port_idx]   = 1'b1;
        occupied[2*port_idx+1] = 1'b1;
        do_write(dest_w'(3), len_w'(8));
        random_writes(12, 1'b1);
        release_all();
        u_checks.close_test("drop");

        repeat (4) do_write(dest_w'(1), len_w'(500));
        do_write(dest_w'(1), len_w'(300));  // the pair has only 24 words left per bank
        do_release(held.pop_front());
        do_write(dest_w'(1), len_w'(300));
        release_all();
        u_checks.close_test("release");

        match_mode = mode_semi_dynamic;
        random_writes(16, 1'b1);
        release_all();
        u_checks.close_test("semi_dynamic");

        match_mode = mode_dynamic;
        random_writes(16, 1'b1);
        release_all();
        u_checks.close_test("dynamic");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 u_checks.tests_run, u_checks.tests_failed, u_checks.err_count);
        if (u_checks.err_count == 0 && u_checks.tests_failed == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* sram_switch.f */
verilog/sram_switch_pkg.sv
verilog/sram_space_tracker.sv
verilog/port_sram_matcher.sv
verilog/port_cmd_ctrl.sv
verilog/sram_switch.sv
verif/sram_switch_checks.sv
verif/sram_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the verdict

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module sram_switch_tb \
    -f sram_switch.f -o sram_switch_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/sram_switch_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"
